//--- design/cipher_pkg.sv
package cipher_pkg;

	// ********************
	// Data types
	// ********************

	// Half [1] is XTEA v0 and half [0] is v1
	typedef logic [1:0][31:0] block_t;

	// Word [0] is XTEA k[0]; the first key beat carries k[0] then k[1]
	typedef logic [3:0][31:0] key_t;

	typedef enum logic [1:0] {
		MODE_ECB = 2'd0,
		MODE_CBC = 2'd1,
		MODE_CTR = 2'd2
	} cipher_mode_e;

	typedef struct packed {
		cipher_mode_e mode;
		logic         decrypt;
	} cipher_cmd_t;

	typedef struct packed {
		block_t data;
		logic   last; // Set on the final data block of a job
	} stream_beat_t;

	typedef struct packed {
		block_t blk;
		logic   decrypt;
	} core_req_t;

	// ********************
	// Constants
	// ********************

	localparam logic [31:0] XTEA_DELTA = 32'h9E37_79B9;
	localparam int DEFAULT_ROUNDS = 32;

endpackage

//--- design/xtea_core.sv
`timescale 1ns/1ps

module xtea_core import cipher_pkg::*; #(
	parameter int ROUNDS = DEFAULT_ROUNDS
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  core_req_t req,
	input  key_t      key,
	output logic      busy,
	output logic      result_valid,
	output block_t    result
);

	localparam int CNT_W = $clog2(ROUNDS + 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(ROUNDS - 1);
	localparam logic [31:0] SUM_DEC = XTEA_DELTA * 32'(ROUNDS); // Wraps modulo 2^32

	logic [CNT_W-1:0] cnt;
	block_t           v;
	logic [31:0]      sum;
	logic [31:0]      sum_step;
	logic             dec;
	logic [31:0]      new_v0;
	logic [31:0]      new_v1;

	function automatic logic [31:0] mix(input logic [31:0] x);
		return ((x << 4) ^ (x >> 5)) + x;
	endfunction

	// ********************
	// One Feistel cycle
	// ********************

	always_comb begin
		if (dec) begin
			sum_step = sum - XTEA_DELTA;
			new_v1 = v[0] - (mix(v[1]) ^ (sum + key[sum[12:11]]));
			new_v0 = v[1] - (mix(new_v1) ^ (sum_step + key[sum_step[1:0]]));
		end else begin
			sum_step = sum + XTEA_DELTA;
			new_v0 = v[1] + (mix(v[0]) ^ (sum + key[sum[1:0]]));
			new_v1 = v[0] + (mix(new_v0) ^ (sum_step + key[sum_step[12:11]]));
		end
	end

	// ********************
	// Sequencing
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			result_valid <= 1'b0;
			cnt <= '0;
		end else begin
			result_valid <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == LAST_CNT) begin
					busy <= 1'b0; // Last cycle lands on this edge
					result_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			v <= req.blk;
			dec <= req.decrypt;
			sum <= req.decrypt ? SUM_DEC : 32'd0;
		end else if (busy) begin
			v <= {new_v0, new_v1};
			sum <= sum_step;
		end
	end

	assign result = v;

endmodule

//--- design/chain_unit.sv
`timescale 1ns/1ps

module chain_unit import cipher_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  cipher_cmd_t cmd,
	input  logic        load_iv,
	input  block_t      iv,
	input  block_t      blk,
	input  logic        advance,
	input  block_t      result,
	output block_t      core_in,
	output block_t      mask
);

	block_t chain_q; // IV, previous ciphertext or counter

	// ********************
	// Core input and mask
	// ********************

	always_comb begin
		case (cmd.mode)
			MODE_CBC: begin
				if (cmd.decrypt) begin
					core_in = blk;
					mask = chain_q; // Previous ciphertext unmasks the plaintext
				end else begin
					core_in = blk ^ chain_q;
					mask = '0;
				end
			end
			MODE_CTR: begin
				core_in = chain_q;
				mask = blk; // Keystream XOR data in both directions
			end
			default: begin
				core_in = blk;
				mask = '0;
			end
		endcase
	end

	// ********************
	// Register update
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			chain_q <= '0;
		end else if (load_iv) begin
			chain_q <= iv;
		end else if (advance) begin
			case (cmd.mode)
				MODE_CBC: chain_q <= cmd.decrypt ? blk : result;
				MODE_CTR: chain_q <= chain_q + 64'd1; // Wraps at 2^64
				default: chain_q <= chain_q;
			endcase
		end
	end

endmodule

//--- design/mode_controller.sv
`timescale 1ns/1ps

module mode_controller import cipher_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  cipher_cmd_t  cmd,
	input  logic         in_valid,
	input  stream_beat_t in_beat,
	output logic         in_ready,
	output logic         out_valid,
	output stream_beat_t out_beat,
	input  logic         out_ready,
	output logic         done,
	output key_t         key,
	output logic         start,
	output core_req_t    req,
	input  logic         result_valid,
	input  block_t       result,
	output logic         load_iv,
	output block_t       iv,
	output block_t       blk,
	output logic         advance,
	input  block_t       core_in,
	input  block_t       mask
);

	typedef enum logic [2:0] {
		KEY_HI,
		KEY_LO,
		IV,
		BLOCK,
		RUN,
		DRAIN
	} state_e;

	state_e state;
	state_e state_next;
	logic   in_fire;
	logic   out_fire;
	logic   launch; // Block held, request goes out next edge
	logic   blk_last;

	assign in_fire = in_valid && in_ready;
	assign out_fire = out_valid && out_ready;

	assign load_iv = (state == IV) && in_fire;
	assign iv = in_beat.data;
	assign advance = (state == RUN) && result_valid;

	// ********************
	// Next state
	// ********************

	always_comb begin
		state_next = state;
		case (state)
			KEY_HI: if (in_fire) state_next = KEY_LO;
			KEY_LO: if (in_fire) state_next = (cmd.mode == MODE_ECB) ? BLOCK : IV;
			IV: if (in_fire) state_next = BLOCK;
			BLOCK: if (in_fire) state_next = RUN;
			RUN: if (result_valid) state_next = DRAIN;
			DRAIN: if (out_fire) state_next = out_beat.last ? KEY_HI : BLOCK;
			default: state_next = KEY_HI;
		endcase
	end

	// ********************
	// Control registers
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= KEY_HI;
			in_ready <= 1'b0;
			out_valid <= 1'b0;
			done <= 1'b0;
			start <= 1'b0;
			launch <= 1'b0;
		end else begin
			state <= state_next;
			in_ready <= (state_next != RUN) && (state_next != DRAIN);
			done <= out_fire && out_beat.last;
			launch <= (state == BLOCK) && in_fire;
			start <= launch;
			if (advance) begin
				out_valid <= 1'b1;
			end else if (out_fire) begin
				out_valid <= 1'b0;
			end
		end
	end

	// ********************
	// Data registers
	// ********************

	always_ff @(posedge clk) begin
		if (state == KEY_HI && in_fire) begin
			key[0] <= in_beat.data[1];
			key[1] <= in_beat.data[0];
		end
		if (state == KEY_LO && in_fire) begin
			key[2] <= in_beat.data[1];
			key[3] <= in_beat.data[0];
		end
		if (state == BLOCK && in_fire) begin
			blk <= in_beat.data;
			blk_last <= in_beat.last;
		end
		if (launch) begin
			req.blk <= core_in;
			req.decrypt <= cmd.decrypt && (cmd.mode != MODE_CTR); // CTR always encrypts
		end
		if (advance) begin
			out_beat.data <= result ^ mask;
			out_beat.last <= blk_last;
		end
	end

endmodule

//--- design/cipher_top.sv
`timescale 1ns/1ps

module cipher_top import cipher_pkg::*; #(
	parameter int ROUNDS = DEFAULT_ROUNDS
) (
	input  logic         clk,
	input  logic         reset,
	input  cipher_cmd_t  cmd,
	input  logic         in_valid,
	input  stream_beat_t in_beat,
	output logic         in_ready,
	output logic         out_valid,
	output stream_beat_t out_beat,
	input  logic         out_ready,
	output logic         done
);

	key_t      key;
	logic      start;
	core_req_t req;
	logic      result_valid;
	block_t    result;
	logic      load_iv;
	block_t    iv;
	block_t    blk;
	logic      advance;
	block_t    core_in;
	block_t    mask;

	mode_controller u_ctrl (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.in_valid(in_valid),
		.in_beat(in_beat),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.out_ready(out_ready),
		.done(done),
		.key(key),
		.start(start),
		.req(req),
		.result_valid(result_valid),
		.result(result),
		.load_iv(load_iv),
		.iv(iv),
		.blk(blk),
		.advance(advance),
		.core_in(core_in),
		.mask(mask)
	);

	xtea_core #(.ROUNDS(ROUNDS)) u_core (
		.clk(clk),
		.reset(reset),
		.start(start),
		.req(req),
		.key(key),
		.busy(),
		.result_valid(result_valid),
		.result(result)
	);

	chain_unit u_chain (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.load_iv(load_iv),
		.iv(iv),
		.blk(blk),
		.advance(advance),
		.result(result),
		.core_in(core_in),
		.mask(mask)
	);

endmodule

//--- verification/cipher_asserts.sv
`timescale 1ns/1ps

module cipher_asserts import cipher_pkg::*; (
	input logic         clk,
	input logic         reset,
	input logic         in_ready,
	input logic         out_valid,
	input stream_beat_t out_beat,
	input logic         out_ready,
	input logic         done
);

	// ********************
	// Stream protocol
	// ********************

	out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
		else $error("Output beat changed or was dropped while out_ready was low");

	in_blocked: assert property (@(posedge clk) disable iff (reset)
		!(out_valid && in_ready))
		else $error("in_ready was high while a result was waiting");

	done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done stayed high for two cycles");

endmodule

//--- verification/tb_cipher_top.sv
`timescale 1ns/1ps

module tb_cipher_top import cipher_pkg::*; ();

	localparam int ROUNDS = 32;
	localparam int NUM_BLOCKS = 20; // Blocks over all jobs below
	localparam int MAX_CYCLES = NUM_BLOCKS * (ROUNDS + 10) + 500;
	localparam logic [31:0] DELTA = 32'h9E37_79B9;

	logic         clk;
	logic         reset;
	cipher_cmd_t  cmd;
	logic         in_valid;
	stream_beat_t in_beat;
	logic         in_ready;
	logic         out_valid;
	stream_beat_t out_beat;
	logic         out_ready;
	logic         done;

	stream_beat_t exp_q[$];
	stream_beat_t exp_beat;
	block_t       src_q[$];
	block_t       res_q[$];
	block_t       plain_q[$];
	block_t       cipher_q[$];
	key_t         key;
	block_t       iv;
	logic         done_due;
	int           jobs_done;
	int           jobs_expected;
	int           cycles;

	cipher_top #(.ROUNDS(ROUNDS)) u_dut (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.in_valid(in_valid),
		.in_beat(in_beat),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.out_ready(out_ready),
		.done(done)
	);

	bind cipher_top cipher_asserts u_asserts (
		.clk(clk),
		.reset(reset),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.out_ready(out_ready),
		.done(done)
	);

	// ********************
	// Reporting
	// ********************

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic report_value(
		input string       name,
		input logic [63:0] got,
		input logic [63:0] exp
	);
		fail_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// ********************
	// Reference model
	// ********************

	function automatic block_t xtea_enc(input block_t b, input key_t k);
		logic [31:0] v0;
		logic [31:0] v1;
		logic [31:0] s;
		v0 = b[1];
		v1 = b[0];
		s = '0;
		for (int i = 0; i < ROUNDS; i++) begin
			v0 += (((v1 << 4) ^ (v1 >> 5)) + v1) ^ (s + k[s[1:0]]);
			s += DELTA;
			v1 += (((v0 << 4) ^ (v0 >> 5)) + v0) ^ (s + k[s[12:11]]);
		end
		return {v0, v1};
	endfunction

	function automatic block_t xtea_dec(input block_t b, input key_t k);
		logic [31:0] v0;
		logic [31:0] v1;
		logic [31:0] s;
		v0 = b[1];
		v1 = b[0];
		s = DELTA * 32'(ROUNDS);
		for (int i = 0; i < ROUNDS; i++) begin
			v1 -= (((v0 << 4) ^ (v0 >> 5)) + v0) ^ (s + k[s[12:11]]);
			s -= DELTA;
			v0 -= (((v1 << 4) ^ (v1 >> 5)) + v1) ^ (s + k[s[1:0]]);
		end
		return {v0, v1};
	endfunction

	task automatic compute_model(input cipher_cmd_t c, input key_t k, input block_t start_iv);
		block_t r;
		block_t o;
		r = start_iv;
		res_q.delete();
		foreach (src_q[i]) begin
			case (c.mode)
				MODE_CBC: begin
					if (c.decrypt) begin
						o = xtea_dec(src_q[i], k) ^ r;
						r = src_q[i];
					end else begin
						o = xtea_enc(src_q[i] ^ r, k);
						r = o;
					end
				end
				MODE_CTR: begin
					o = xtea_enc(r, k) ^ src_q[i];
					r = r + 64'd1;
				end
				default: o = c.decrypt ? xtea_dec(src_q[i], k) : xtea_enc(src_q[i], k);
			endcase
			res_q.push_back(o);
		end
	endtask

	// ********************
	// Stimulus
	// ********************

	function automatic block_t rand_block();
		return {$urandom, $urandom};
	endfunction

	task automatic send_beat(input block_t d, input logic last);
		in_valid = 1'b1;
		in_beat.data = d;
		in_beat.last = last;
		while (!in_ready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk); // Beat moves on this edge
		#1;
		in_valid = 1'b0;
	endtask

	task automatic run_job(input cipher_cmd_t c, input key_t k, input block_t start_iv);
		stream_beat_t e;
		foreach (res_q[i]) begin
			e.data = res_q[i];
			e.last = (i == res_q.size() - 1);
			exp_q.push_back(e);
		end
		cmd = c;
		send_beat({k[0], k[1]}, 1'b0);
		send_beat({k[2], k[3]}, 1'b0);
		if (c.mode != MODE_ECB) begin
			send_beat(start_iv, 1'b0);
		end
		foreach (src_q[i]) begin
			send_beat(src_q[i], i == src_q.size() - 1);
		end
		jobs_expected++;
		wait (jobs_done == jobs_expected);
		@(posedge clk);
		#1;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		#1;
		out_ready = ($urandom % 4) != 0; // Stall about one cycle in four
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			fail_run($sformatf("Timeout after %0d cycles with jobs unfinished", cycles));
		end
	end

	// ********************
	// Output checking
	// ********************

	always @(negedge clk) begin
		if (!reset) begin
			assert (done == done_due) else report_value("done", 64'(done), 64'(done_due));
			if (done) jobs_done++;
			done_due = 1'b0;
			if (out_valid && out_ready) begin
				assert (exp_q.size() > 0)
					else fail_run("Output beat arrived with no result expected");
				exp_beat = exp_q.pop_front();
				done_due = exp_beat.last; // Job ends one cycle after its last result
				assert (out_beat.data == exp_beat.data)
					else report_value("out_beat.data", out_beat.data, exp_beat.data);
				assert (out_beat.last == exp_beat.last)
					else report_value("out_beat.last", 64'(out_beat.last), 64'(exp_beat.last));
			end
		end
	end

	initial begin
		void'($urandom(40179));
		reset = 1'b1;
		cmd = '{mode: MODE_ECB, decrypt: 1'b0};
		in_valid = 1'b0;
		in_beat = '0;
		out_ready = 1'b0;
		done_due = 1'b0;
		jobs_done = 0;
		jobs_expected = 0;
		cycles = 0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// Published vector, expected value taken as given
		key = 128'h0c0d0e0f_08090a0b_04050607_00010203;
		src_q = '{64'h41424344_45464748};
		res_q = '{64'h497df3d0_72612cb5};
		run_job('{mode: MODE_ECB, decrypt: 1'b0}, key, '0);

		key = {$urandom, $urandom, $urandom, $urandom};
		src_q = '{rand_block(), rand_block(), rand_block()};
		compute_model('{mode: MODE_ECB, decrypt: 1'b1}, key, '0);
		run_job('{mode: MODE_ECB, decrypt: 1'b1}, key, '0);

		key = {$urandom, $urandom, $urandom, $urandom};
		iv = rand_block();
		src_q = '{rand_block(), rand_block(), rand_block(), rand_block()};
		plain_q = src_q;
		compute_model('{mode: MODE_CBC, decrypt: 1'b0}, key, iv);
		cipher_q = res_q;
		run_job('{mode: MODE_CBC, decrypt: 1'b0}, key, iv);

		src_q = cipher_q;
		res_q = plain_q;
		run_job('{mode: MODE_CBC, decrypt: 1'b1}, key, iv);

		key = {$urandom, $urandom, $urandom, $urandom};
		iv = 64'hFFFF_FFFF_FFFF_FFFE; // Counter wraps on the third block
		src_q = '{rand_block(), rand_block(), rand_block(), rand_block()};
		plain_q = src_q;
		compute_model('{mode: MODE_CTR, decrypt: 1'b0}, key, iv);
		cipher_q = res_q;
		run_job('{mode: MODE_CTR, decrypt: 1'b0}, key, iv);

		src_q = cipher_q;
		res_q = plain_q;
		run_job('{mode: MODE_CTR, decrypt: 1'b1}, key, iv);

		if (exp_q.size() != 0 || jobs_done != jobs_expected) begin
			fail_run("Run ended with results still outstanding");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

//--- all.f
design/cipher_pkg.sv
design/xtea_core.sv
design/chain_unit.sv
design/mode_controller.sv
design/cipher_top.sv
verification/cipher_asserts.sv
verification/tb_cipher_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cipher_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
